/* run.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and look for the pass line in the log
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -j 0 --top-module tb_top \
    -Gtimer_prescale=5 -f tb.f -o Vtb_top

./obj_dir/Vtb_top +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -qx "SIMULATION PASSED" sim.log; then
    exit 0
fi
exit 1

/* source/cpu_bus_if.sv */
/*
 * CPU bus cycle from the top level to the peripheral units
 */
`timescale 1ns/1ps
`include "mcu_settings.svh"

interface cpu_bus_if;

    logic                   cycle;
    logic [`MCU_ADDR_W-1:0] addr;
    logic                   wr;
    logic [`MCU_DATA_W-1:0] wdata;

    // Side that stands in for the core
    modport host (
        output cycle, addr, wr, wdata
    );

    // Register units
    modport periph (
        input cycle, addr, wr, wdata
    );

endinterface

/* source/io_ports.sv */
/*
 * Parallel ports A to C with direction registers, input-only port D
 */
`timescale 1ns/1ps
`include "mcu_settings.svh"

module io_ports (
    input  logic                   clk30,
    input  logic                   reset,
    cpu_bus_if.periph              bus,
    input  logic [`MCU_DATA_W-1:0] porta_in,
    input  logic [`MCU_DATA_W-1:0] portb_in,
    input  logic [`MCU_DATA_W-1:0] portc_in,
    input  logic [`MCU_DATA_W-1:0] portd_in,
    output logic [`MCU_DATA_W-1:0] porta_out,
    output logic [`MCU_DATA_W-1:0] portb_out,
    output logic [`MCU_DATA_W-1:0] portc_out,
    output logic [`MCU_DATA_W-1:0] ddra,
    output logic [`MCU_DATA_W-1:0] ddrb,
    output logic [`MCU_DATA_W-1:0] ddrc,
    output logic [`MCU_DATA_W-1:0] rdata
);

    // Output bits where the direction is 1, pin level elsewhere
    function automatic logic [`MCU_DATA_W-1:0] port_mix(
        input logic [`MCU_DATA_W-1:0] out_q,
        input logic [`MCU_DATA_W-1:0] dir,
        input logic [`MCU_DATA_W-1:0] pin
    );
        return (out_q & dir) | (pin & ~dir);
    endfunction

    always_ff @(posedge clk30) begin
        if (reset) begin
            porta_out <= '0;
            portb_out <= '0;
            portc_out <= '0;
            ddra      <= '0;
            ddrb      <= '0;
            ddrc      <= '0;
        end else if (bus.cycle && bus.wr) begin
            case (bus.addr)
                mcu_pkg::ADR_PORTA: porta_out <= bus.wdata;
                mcu_pkg::ADR_PORTB: portb_out <= bus.wdata;
                mcu_pkg::ADR_PORTC: portc_out <= bus.wdata;
                mcu_pkg::ADR_DDRA:  ddra      <= bus.wdata;
                mcu_pkg::ADR_DDRB:  ddrb      <= bus.wdata;
                mcu_pkg::ADR_DDRC:  ddrc      <= bus.wdata;
                default: ;
            endcase
        end
    end

    always_comb begin
        rdata = '0;
        case (bus.addr)
            mcu_pkg::ADR_PORTA: rdata = port_mix(porta_out, ddra, porta_in);
            mcu_pkg::ADR_PORTB: rdata = port_mix(portb_out, ddrb, portb_in);
            mcu_pkg::ADR_PORTC: rdata = port_mix(portc_out, ddrc, portc_in);
            // Port D has no output driver
            mcu_pkg::ADR_PORTD: rdata = portd_in;
            mcu_pkg::ADR_DDRA:  rdata = ddra;
            mcu_pkg::ADR_DDRB:  rdata = ddrb;
            mcu_pkg::ADR_DDRC:  rdata = ddrc;
            default: ;
        endcase
    end

endmodule

/* source/mcu_periph_top.sv */
/*
 * Peripheral block top level: bus onto the interface, port, timer
 * and serial units, read data merge
 */
`timescale 1ns/1ps
`include "mcu_settings.svh"

module mcu_periph_top #(
    parameter int timer_prescale = `MCU_TIMER_PRESCALE
) (
    input  logic                   clk30,
    input  logic                   reset,
    input  logic                   cycle,
    input  logic [`MCU_ADDR_W-1:0] addr,
    input  logic                   wr,
    input  logic [`MCU_DATA_W-1:0] wdata,
    output logic [`MCU_DATA_W-1:0] rdata,
    input  logic [`MCU_DATA_W-1:0] porta_in,
    input  logic [`MCU_DATA_W-1:0] portb_in,
    input  logic [`MCU_DATA_W-1:0] portc_in,
    input  logic [`MCU_DATA_W-1:0] portd_in,
    output logic [`MCU_DATA_W-1:0] porta_out,
    output logic [`MCU_DATA_W-1:0] portb_out,
    output logic [`MCU_DATA_W-1:0] portc_out,
    output logic [`MCU_DATA_W-1:0] ddra,
    output logic [`MCU_DATA_W-1:0] ddrb,
    output logic [`MCU_DATA_W-1:0] ddrc,
    input  logic                   tcap,
    output logic                   timer_irq,
    input  logic                   rx_valid,
    input  logic [`MCU_DATA_W-1:0] rx_data,
    output logic                   tx_valid,
    output logic [`MCU_DATA_W-1:0] tx_data,
    output logic                   sci_irq
);

    logic [`MCU_DATA_W-1:0] io_rdata;
    logic [`MCU_DATA_W-1:0] tmr_rdata;
    logic [`MCU_DATA_W-1:0] sci_rdata;

    cpu_bus_if bus_i ();

    assign bus_i.cycle = cycle;
    assign bus_i.addr  = addr;
    assign bus_i.wr    = wr;
    assign bus_i.wdata = wdata;

    io_ports io_ports_i (
        .clk30     (clk30),
        .reset     (reset),
        .bus       (bus_i.periph),
        .porta_in  (porta_in),
        .portb_in  (portb_in),
        .portc_in  (portc_in),
        .portd_in  (portd_in),
        .porta_out (porta_out),
        .portb_out (portb_out),
        .portc_out (portc_out),
        .ddra      (ddra),
        .ddrb      (ddrb),
        .ddrc      (ddrc),
        .rdata     (io_rdata)
    );

    timer_unit #(
        .prescale (timer_prescale)
    ) timer_unit_i (
        .clk30     (clk30),
        .reset     (reset),
        .bus       (bus_i.periph),
        .tcap      (tcap),
        .timer_irq (timer_irq),
        .rdata     (tmr_rdata)
    );

    sci_regs sci_regs_i (
        .clk30    (clk30),
        .reset    (reset),
        .bus      (bus_i.periph),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .tx_valid (tx_valid),
        .tx_data  (tx_data),
        .sci_irq  (sci_irq),
        .rdata    (sci_rdata)
    );

    // Each unit returns zero outside its own addresses
    assign rdata = io_rdata | tmr_rdata | sci_rdata;

endmodule

/* source/mcu_pkg.sv */
/*
 * Shared types of the peripheral block: register address enum,
 * timer control and status, serial status and serial control 2
 */
`include "mcu_settings.svh"

package mcu_pkg;

    // Fixed 16-bit decode of the peripheral registers
    typedef enum logic [`MCU_ADDR_W-1:0] {
        ADR_PORTA  = `MCU_ADR_PORTA,
        ADR_PORTB  = `MCU_ADR_PORTB,
        ADR_PORTC  = `MCU_ADR_PORTC,
        ADR_PORTD  = `MCU_ADR_PORTD,
        ADR_DDRA   = `MCU_ADR_DDRA,
        ADR_DDRB   = `MCU_ADR_DDRB,
        ADR_DDRC   = `MCU_ADR_DDRC,
        ADR_SCBR   = `MCU_ADR_SCBR,
        ADR_SCCR1  = `MCU_ADR_SCCR1,
        ADR_SCCR2  = `MCU_ADR_SCCR2,
        ADR_SCSR   = `MCU_ADR_SCSR,
        ADR_SCDR   = `MCU_ADR_SCDR,
        ADR_TCR    = `MCU_ADR_TCR,
        ADR_TSR    = `MCU_ADR_TSR,
        ADR_ICH    = `MCU_ADR_ICH,
        ADR_ICL    = `MCU_ADR_ICL,
        ADR_OCH    = `MCU_ADR_OCH,
        ADR_OCL    = `MCU_ADR_OCL,
        ADR_ALT_HI = `MCU_ADR_ALT_HI,
        ADR_ALT_LO = `MCU_ADR_ALT_LO
    } reg_addr_e;

    // Timer control
    typedef struct packed {
        logic       icie;       // capture interrupt enable
        logic       ocie;       // compare interrupt enable
        logic       toie;
        logic [2:0] reserved;
        logic       iedg;       // 1 selects rising tcap edge
        logic       olvl;
    } tcr_t;

    // Timer status
    typedef struct packed {
        logic       icf;
        logic       ocf;
        logic       tof;
        logic [4:0] reserved;
    } tsr_t;

    // Serial status
    typedef struct packed {
        logic tdre;
        logic tc;
        logic rdrf;
        logic idle;
        logic overrun;
        logic nf;
        logic fe;
        logic reserved;
    } scsr_t;

    // Serial control 2
    typedef struct packed {
        logic tie;
        logic tcie;
        logic rie;
        logic ilie;
        logic te;
        logic re;
        logic rwu;
        logic sbk;
    } sccr2_t;

endpackage

/* source/mcu_settings.svh */
/*
 * Bus widths, register address map, timer prescale period
 * and serial status reset value of the 68HC05 peripheral block
 */
`ifndef MCU_SETTINGS_SVH
`define MCU_SETTINGS_SVH

// CPU bus geometry
`define MCU_DATA_W 8
`define MCU_ADDR_W 16

// Parallel ports and direction registers
`define MCU_ADR_PORTA 16'h0000
`define MCU_ADR_PORTB 16'h0001
`define MCU_ADR_PORTC 16'h0002
`define MCU_ADR_PORTD 16'h0003
`define MCU_ADR_DDRA 16'h0004
`define MCU_ADR_DDRB 16'h0005
`define MCU_ADR_DDRC 16'h0006

// Serial communications interface
`define MCU_ADR_SCBR 16'h000D
`define MCU_ADR_SCCR1 16'h000E
`define MCU_ADR_SCCR2 16'h000F
`define MCU_ADR_SCSR 16'h0010
`define MCU_ADR_SCDR 16'h0011

// Timer
`define MCU_ADR_TCR 16'h0012
`define MCU_ADR_TSR 16'h0013
`define MCU_ADR_ICH 16'h0014
`define MCU_ADR_ICL 16'h0015
`define MCU_ADR_OCH 16'h0016
`define MCU_ADR_OCL 16'h0017
`define MCU_ADR_ALT_HI 16'h001A
`define MCU_ADR_ALT_LO 16'h001B

// Bus cycles per counter tick, 30 MHz / 2 / 30 on the real part
`define MCU_TIMER_PRESCALE 30

// Transmit empty and transmit complete set out of reset
`define MCU_SCSR_RESET 8'hC0

`endif

/* source/sci_regs.sv */
/*
 * Serial communications interface registers: baud, control, status,
 * receive buffer with full flag, transmit strobe and receive interrupt
 */
`timescale 1ns/1ps
`include "mcu_settings.svh"

module sci_regs (
    input  logic                   clk30,
    input  logic                   reset,
    cpu_bus_if.periph              bus,
    input  logic                   rx_valid,
    input  logic [`MCU_DATA_W-1:0] rx_data,
    output logic                   tx_valid,
    output logic [`MCU_DATA_W-1:0] tx_data,
    output logic                   sci_irq,
    output logic [`MCU_DATA_W-1:0] rdata
);

    logic [`MCU_DATA_W-1:0] scbr;
    logic [`MCU_DATA_W-1:0] sccr1;
    logic [`MCU_DATA_W-1:0] rx_buf;
    mcu_pkg::sccr2_t        sccr2;
    mcu_pkg::scsr_t         scsr;
    logic                   scdr_hit;

    assign scdr_hit = bus.cycle && (bus.addr == mcu_pkg::ADR_SCDR);

    // Transmit byte goes straight out with the write cycle
    assign tx_valid = scdr_hit && bus.wr;
    assign tx_data  = bus.wdata;

    assign sci_irq = sccr2.rie && scsr.rdrf;

    always_ff @(posedge clk30) begin
        if (reset) begin
            scbr  <= '0;
            sccr1 <= '0;
            sccr2 <= '0;
            scsr  <= mcu_pkg::scsr_t'(`MCU_SCSR_RESET);
        end else begin
            if (bus.cycle && bus.wr) begin
                case (bus.addr)
                    mcu_pkg::ADR_SCBR:  scbr  <= bus.wdata;
                    mcu_pkg::ADR_SCCR1: sccr1 <= bus.wdata;
                    mcu_pkg::ADR_SCCR2: sccr2 <= mcu_pkg::sccr2_t'(bus.wdata);
                    default: ;
                endcase
            end
            if (scdr_hit && !bus.wr) begin
                scsr.rdrf <= 1'b0;
            end
            // A new byte in the same clock keeps the flag set
            if (rx_valid) begin
                scsr.rdrf <= 1'b1;
            end
        end
    end

    // Receive buffer, overwritten by every byte
    always_ff @(posedge clk30) begin
        if (rx_valid) begin
            rx_buf <= rx_data;
        end
    end

    always_comb begin
        rdata = '0;
        case (bus.addr)
            mcu_pkg::ADR_SCBR:  rdata = scbr;
            mcu_pkg::ADR_SCCR1: rdata = sccr1;
            mcu_pkg::ADR_SCCR2: rdata = sccr2;
            mcu_pkg::ADR_SCSR:  rdata = scsr;
            mcu_pkg::ADR_SCDR:  rdata = rx_buf;
            default: ;
        endcase
    end

endmodule

/* source/timer_unit.sv */
/*
 * 16-bit free-running timer: prescaler, output compare, input capture
 * with edge select, alternate counter low-byte latch and timer interrupt
 */
`timescale 1ns/1ps
`include "mcu_settings.svh"

module timer_unit #(
    parameter int prescale = `MCU_TIMER_PRESCALE
) (
    input  logic                   clk30,
    input  logic                   reset,
    cpu_bus_if.periph              bus,
    input  logic                   tcap,
    output logic                   timer_irq,
    output logic [`MCU_DATA_W-1:0] rdata
);

    localparam int presc_w = (prescale > 1) ? $clog2(prescale) : 1;
    localparam logic [presc_w-1:0] presc_last = presc_w'(prescale - 1);

    logic [presc_w-1:0]     presc_cnt;
    logic [15:0]            counter;
    logic [15:0]            ocr;
    logic [15:0]            icr;
    logic [`MCU_DATA_W-1:0] alt_lo_q;
    logic                   tcap_q;
    logic                   cap_edge;
    mcu_pkg::tcr_t          tcr;
    mcu_pkg::tsr_t          tsr;

    // Edge between the previous and the current bus-cycle sample
    assign cap_edge = tcr.iedg ? (tcap && !tcap_q) : (!tcap && tcap_q);

    always_ff @(posedge clk30) begin
        if (reset) begin
            presc_cnt <= '0;
            counter   <= '0;
            ocr       <= '0;
            alt_lo_q  <= '0;
            tcap_q    <= 1'b0;
            tcr       <= '0;
            tsr       <= '0;
            timer_irq <= 1'b0;
        end else if (bus.cycle) begin
            // Interrupt pulse lasts one bus cycle
            timer_irq <= 1'b0;
            tcap_q    <= tcap;

            if (presc_cnt == presc_last) begin
                presc_cnt <= '0;
                counter   <= counter + 16'd1;
                if (counter == 16'hFFFF) begin
                    tsr.tof <= 1'b1;
                end
            end else begin
                presc_cnt <= presc_cnt + 1'b1;
            end

            if (counter == ocr) begin
                tsr.ocf <= 1'b1;
                if (tcr.ocie) begin
                    timer_irq <= 1'b1;
                end
            end

            if (cap_edge) begin
                tsr.icf <= 1'b1;
                if (tcr.icie) begin
                    timer_irq <= 1'b1;
                end
            end

            // Bus side effects come last so a clear wins over a set
            if (bus.wr) begin
                case (bus.addr)
                    mcu_pkg::ADR_TCR: tcr <= mcu_pkg::tcr_t'(bus.wdata);
                    mcu_pkg::ADR_OCH: ocr[15:8] <= bus.wdata;
                    mcu_pkg::ADR_OCL: begin
                        ocr[7:0] <= bus.wdata;
                        tsr.ocf  <= 1'b0;
                    end
                    default: ;
                endcase
            end else begin
                case (bus.addr)
                    // High byte read freezes the low byte for the next read
                    mcu_pkg::ADR_ALT_HI: alt_lo_q <= counter[7:0];
                    mcu_pkg::ADR_ALT_LO: tsr.tof <= 1'b0;
                    mcu_pkg::ADR_ICL:    tsr.icf <= 1'b0;
                    default: ;
                endcase
            end
        end
    end

    // Capture register
    always_ff @(posedge clk30) begin
        if (bus.cycle && cap_edge) begin
            icr <= counter;
        end
    end

    always_comb begin
        rdata = '0;
        case (bus.addr)
            mcu_pkg::ADR_TCR:    rdata = tcr;
            mcu_pkg::ADR_TSR:    rdata = tsr;
            mcu_pkg::ADR_ICH:    rdata = icr[15:8];
            mcu_pkg::ADR_ICL:    rdata = icr[7:0];
            mcu_pkg::ADR_OCH:    rdata = ocr[15:8];
            mcu_pkg::ADR_OCL:    rdata = ocr[7:0];
            mcu_pkg::ADR_ALT_HI: rdata = counter[15:8];
            mcu_pkg::ADR_ALT_LO: rdata = alt_lo_q;
            default: ;
        endcase
    end

endmodule

/* tb.f */
+incdir+source
source/mcu_pkg.sv
source/cpu_bus_if.sv
source/io_ports.sv
source/timer_unit.sv
source/sci_regs.sv
source/mcu_periph_top.sv
testbench/mcu_periph_chk.sv
testbench/tb_top.sv

/* testbench/mcu_periph_chk.sv */
/*
 * Bound checker of the peripheral block: shadow registers, bus-cycle
 * count and concurrent assertions on outputs, strobes and read data
 */
`timescale 1ns/1ps
`include "mcu_settings.svh"

module mcu_periph_chk #(
    parameter int prescale = `MCU_TIMER_PRESCALE
) (
    input logic                   clk30,
    input logic                   reset,
    input logic                   cycle,
    input logic [`MCU_ADDR_W-1:0] addr,
    input logic                   wr,
    input logic [`MCU_DATA_W-1:0] wdata,
    input logic [`MCU_DATA_W-1:0] rdata,
    input logic [`MCU_DATA_W-1:0] porta_in,
    input logic [`MCU_DATA_W-1:0] portb_in,
    input logic [`MCU_DATA_W-1:0] portc_in,
    input logic [`MCU_DATA_W-1:0] portd_in,
    input logic [`MCU_DATA_W-1:0] porta_out,
    input logic [`MCU_DATA_W-1:0] portb_out,
    input logic [`MCU_DATA_W-1:0] portc_out,
    input logic [`MCU_DATA_W-1:0] ddra,
    input logic [`MCU_DATA_W-1:0] ddrb,
    input logic [`MCU_DATA_W-1:0] ddrc,
    input logic                   tcap,
    input logic                   timer_irq,
    input logic                   rx_valid,
    input logic [`MCU_DATA_W-1:0] rx_data,
    input logic                   tx_valid,
    input logic [`MCU_DATA_W-1:0] tx_data,
    input logic                   sci_irq
);

    int fail_count = 0;

    // Shadow registers, port index taken from addr[1:0]
    logic [7:0]  sh_out [3];
    logic [7:0]  sh_ddr [3];
    logic [7:0]  sh_scbr;
    logic [7:0]  sh_sccr1;
    logic [7:0]  sh_sccr2;
    logic [7:0]  sh_rx_buf;
    logic        sh_rx_seen;
    logic        sh_rdrf;
    logic [7:0]  sh_tcr;
    logic [15:0] sh_ocr;
    logic [15:0] sh_icr;
    logic        sh_cap_seen;
    logic        sh_icf;
    logic        sh_ocf;
    logic [7:0]  sh_alt_lo;
    logic        sh_tcap_q;
    logic        sh_irq;
    logic        sh_irq_en;
    int unsigned bus_cycles;
    logic [15:0] tick;
    logic        cap_edge;
    logic        wr_cyc;
    logic        rd_cyc;
    logic [7:0]  exp_rdata;
    logic        exp_known;

    assign wr_cyc = cycle && wr;
    assign rd_cyc = cycle && !wr;

    // Counter value expected from the bus cycles seen so far
    assign tick = 16'(bus_cycles / prescale);

    // TCR bit 1 picks the rising edge
    assign cap_edge = cycle && (sh_tcr[1] ? (tcap && !sh_tcap_q) : (!tcap && sh_tcap_q));

    always_ff @(posedge clk30) begin
        if (reset) begin
            sh_out      <= '{default: '0};
            sh_ddr      <= '{default: '0};
            sh_scbr     <= '0;
            sh_sccr1    <= '0;
            sh_sccr2    <= '0;
            sh_rx_seen  <= 1'b0;
            sh_rdrf     <= 1'b0;
            sh_tcr      <= '0;
            sh_ocr      <= '0;
            sh_icr      <= '0;
            sh_cap_seen <= 1'b0;
            sh_icf      <= 1'b0;
            sh_ocf      <= 1'b0;
            sh_alt_lo   <= '0;
            sh_tcap_q   <= 1'b0;
            sh_irq      <= 1'b0;
            sh_irq_en   <= 1'b0;
            bus_cycles  <= 0;
        end else begin
            if (cycle) begin
                bus_cycles <= bus_cycles + 1;
                sh_tcap_q  <= tcap;
                sh_irq_en  <= sh_tcr[7] || sh_tcr[6];
                sh_irq     <= ((tick == sh_ocr) && sh_tcr[6]) || (cap_edge && sh_tcr[7]);
                if (tick == sh_ocr) begin
                    sh_ocf <= 1'b1;
                end
                if (cap_edge) begin
                    sh_icf      <= 1'b1;
                    sh_icr      <= tick;
                    sh_cap_seen <= 1'b1;
                end
            end
            if (wr_cyc) begin
                case (addr)
                    `MCU_ADR_PORTA, `MCU_ADR_PORTB, `MCU_ADR_PORTC: sh_out[addr[1:0]] <= wdata;
                    `MCU_ADR_DDRA, `MCU_ADR_DDRB, `MCU_ADR_DDRC: sh_ddr[addr[1:0]] <= wdata;
                    `MCU_ADR_SCBR:  sh_scbr <= wdata;
                    `MCU_ADR_SCCR1: sh_sccr1 <= wdata;
                    `MCU_ADR_SCCR2: sh_sccr2 <= wdata;
                    `MCU_ADR_TCR:   sh_tcr <= wdata;
                    `MCU_ADR_OCH:   sh_ocr[15:8] <= wdata;
                    `MCU_ADR_OCL: begin
                        sh_ocr[7:0] <= wdata;
                        sh_ocf      <= 1'b0;
                    end
                    default: ;
                endcase
            end
            if (rd_cyc) begin
                case (addr)
                    `MCU_ADR_SCDR:   sh_rdrf <= 1'b0;
                    `MCU_ADR_ICL:    sh_icf <= 1'b0;
                    `MCU_ADR_ALT_HI: sh_alt_lo <= tick[7:0];
                    default: ;
                endcase
            end
            // A byte in the same clock as the SCDR read leaves the flag set
            if (rx_valid) begin
                sh_rx_buf  <= rx_data;
                sh_rx_seen <= 1'b1;
                sh_rdrf    <= 1'b1;
            end
        end
    end

    always_comb begin
        exp_known = 1'b1;
        exp_rdata = '0;
        case (addr)
            `MCU_ADR_PORTA: exp_rdata = (sh_out[0] & sh_ddr[0]) | (porta_in & ~sh_ddr[0]);
            `MCU_ADR_PORTB: exp_rdata = (sh_out[1] & sh_ddr[1]) | (portb_in & ~sh_ddr[1]);
            `MCU_ADR_PORTC: exp_rdata = (sh_out[2] & sh_ddr[2]) | (portc_in & ~sh_ddr[2]);
            `MCU_ADR_PORTD: exp_rdata = portd_in;
            `MCU_ADR_DDRA, `MCU_ADR_DDRB, `MCU_ADR_DDRC: exp_rdata = sh_ddr[addr[1:0]];
            `MCU_ADR_SCBR:  exp_rdata = sh_scbr;
            `MCU_ADR_SCCR1: exp_rdata = sh_sccr1;
            `MCU_ADR_SCCR2: exp_rdata = sh_sccr2;
            // Transmit empty and complete stay set
            `MCU_ADR_SCSR:  exp_rdata = {2'b11, sh_rdrf, 5'b00000};
            `MCU_ADR_SCDR: begin
                exp_rdata = sh_rx_buf;
                exp_known = sh_rx_seen;
            end
            `MCU_ADR_TCR: exp_rdata = sh_tcr;
            `MCU_ADR_TSR: exp_rdata = {sh_icf, sh_ocf, 6'b000000};
            `MCU_ADR_ICH: begin
                exp_rdata = sh_icr[15:8];
                exp_known = sh_cap_seen;
            end
            `MCU_ADR_ICL: begin
                exp_rdata = sh_icr[7:0];
                exp_known = sh_cap_seen;
            end
            `MCU_ADR_OCH:    exp_rdata = sh_ocr[15:8];
            `MCU_ADR_OCL:    exp_rdata = sh_ocr[7:0];
            `MCU_ADR_ALT_HI: exp_rdata = tick[15:8];
            `MCU_ADR_ALT_LO: exp_rdata = sh_alt_lo;
            default: ;
        endcase
    end

    out_regs_a: assert property (@(posedge clk30) disable iff (reset)
        porta_out == sh_out[0] && portb_out == sh_out[1] && portc_out == sh_out[2])
        else begin
            fail_count++;
            $error("ERROR porta_out/portb_out/portc_out %h %h %h expected %h %h %h",
                $sampled(porta_out), $sampled(portb_out), $sampled(portc_out),
                $sampled(sh_out[0]), $sampled(sh_out[1]), $sampled(sh_out[2]));
        end

    ddr_regs_a: assert property (@(posedge clk30) disable iff (reset)
        ddra == sh_ddr[0] && ddrb == sh_ddr[1] && ddrc == sh_ddr[2])
        else begin
            fail_count++;
            $error("ERROR ddra/ddrb/ddrc %h %h %h expected %h %h %h",
                $sampled(ddra), $sampled(ddrb), $sampled(ddrc),
                $sampled(sh_ddr[0]), $sampled(sh_ddr[1]), $sampled(sh_ddr[2]));
        end

    read_data_a: assert property (@(posedge clk30) disable iff (reset)
        (rd_cyc && exp_known) |-> (rdata == exp_rdata))
        else begin
            fail_count++;
            $error("ERROR rdata %h expected %h at addr %h",
                $sampled(rdata), $sampled(exp_rdata), $sampled(addr));
        end

    tx_strobe_a: assert property (@(posedge clk30) disable iff (reset)
        tx_valid == (wr_cyc && addr == `MCU_ADR_SCDR))
        else begin
            fail_count++;
            $error("ERROR tx_valid %h at addr %h", $sampled(tx_valid), $sampled(addr));
        end

    tx_data_a: assert property (@(posedge clk30) disable iff (reset)
        tx_valid |-> (tx_data == wdata))
        else begin
            fail_count++;
            $error("ERROR tx_data %h expected %h", $sampled(tx_data), $sampled(wdata));
        end

    // Receive interrupt is rie and rdrf
    sci_irq_a: assert property (@(posedge clk30) disable iff (reset)
        sci_irq == (sh_sccr2[5] && sh_rdrf))
        else begin
            fail_count++;
            $error("ERROR sci_irq %h expected %h",
                $sampled(sci_irq), $sampled(sh_sccr2[5] && sh_rdrf));
        end

    timer_irq_a: assert property (@(posedge clk30) disable iff (reset)
        timer_irq == sh_irq)
        else begin
            fail_count++;
            $error("ERROR timer_irq %h expected %h", $sampled(timer_irq), $sampled(sh_irq));
        end

    irq_enable_a: assert property (@(posedge clk30) disable iff (reset)
        timer_irq |-> sh_irq_en)
        else begin
            fail_count++;
            $error("Timer interrupt raised while both timer interrupt enables were off");
        end

endmodule

/* testbench/tb_top.sv */
/*
 * Testbench top: clock and reset, CPU bus tasks in place of the core,
 * port, serial and timer tests, per-test lines and the final verdict
 */
`timescale 1ns/1ps
`include "mcu_settings.svh"

module tb_top #(
    parameter int timer_prescale = 5
);

    // The tests need about 1500 clocks
    localparam int max_cycles = 4000;

    logic                   clk30;
    logic                   reset;
    logic                   cycle;
    logic [`MCU_ADDR_W-1:0] addr;
    logic                   wr;
    logic [`MCU_DATA_W-1:0] wdata;
    logic [`MCU_DATA_W-1:0] rdata;
    logic [`MCU_DATA_W-1:0] porta_in;
    logic [`MCU_DATA_W-1:0] portb_in;
    logic [`MCU_DATA_W-1:0] portc_in;
    logic [`MCU_DATA_W-1:0] portd_in;
    logic [`MCU_DATA_W-1:0] porta_out;
    logic [`MCU_DATA_W-1:0] portb_out;
    logic [`MCU_DATA_W-1:0] portc_out;
    logic [`MCU_DATA_W-1:0] ddra;
    logic [`MCU_DATA_W-1:0] ddrb;
    logic [`MCU_DATA_W-1:0] ddrc;
    logic                   tcap;
    logic                   timer_irq;
    logic                   rx_valid;
    logic [`MCU_DATA_W-1:0] rx_data;
    logic                   tx_valid;
    logic [`MCU_DATA_W-1:0] tx_data;
    logic                   sci_irq;

    int seed = 70335;
    int bus_cycles = 0;
    int tb_errors = 0;
    int tests_run = 0;
    int fails_before = 0;
    int cycles = 0;

    mcu_periph_top #(
        .timer_prescale (timer_prescale)
    ) dut_i (.*);

    bind mcu_periph_top mcu_periph_chk #(.prescale(timer_prescale)) chk_i (.*);

    initial begin
        clk30 = 1'b0;
        forever #4 clk30 = ~clk30;
    end

    initial begin
        while (cycles < max_cycles) begin
            @(posedge clk30);
            cycles++;
        end
        $display("Timeout: no verdict after %0d clocks", max_cycles);
        $display("SIMULATION FAILED");
        $finish;
    end

    function automatic logic [7:0] rand8();
        return 8'($random(seed));
    endfunction

    task automatic idle_gap();
        int n;
        n = $random(seed) & 3;
        repeat (n) @(negedge clk30);
    endtask

    // Called on a falling edge, returns on a falling edge
    task automatic bus_cycle(input logic [15:0] a, input logic w, input logic [7:0] d);
        cycle = 1'b1;
        addr  = a;
        wr    = w;
        wdata = d;
        @(negedge clk30);
        cycle = 1'b0;
        wr    = 1'b0;
        bus_cycles++;
        idle_gap();
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        bus_cycle(a, 1'b1, d);
    endtask

    task automatic bus_read(input logic [15:0] a);
        bus_cycle(a, 1'b0, 8'h00);
    endtask

    task automatic rx_byte(input logic [7:0] d);
        rx_valid = 1'b1;
        rx_data  = d;
        @(negedge clk30);
        rx_valid = 1'b0;
    endtask

    task automatic wait_timer_irq(input string what);
        int n;
        n = 0;
        while (!timer_irq && n < 60) begin
            bus_read(`MCU_ADR_TSR);
            n++;
        end
        if (!timer_irq) begin
            tb_errors++;
            $display("The %s interrupt did not come within %0d bus cycles", what, n);
        end
    endtask

    task automatic open_test();
        fails_before = dut_i.chk_i.fail_count + tb_errors;
    endtask

    task automatic close_test(input string name);
        int n;
        n = dut_i.chk_i.fail_count + tb_errors - fails_before;
        tests_run++;
        $display("test %s: %0d failures", name, n);
    endtask

    task automatic test_ports();
        open_test();
        for (int i = 0; i < 6; i++) begin
            porta_in = rand8();
            portb_in = rand8();
            portc_in = rand8();
            portd_in = rand8();
            for (int p = 0; p < 3; p++) begin
                bus_write(16'(`MCU_ADR_DDRA + p), rand8());
                bus_write(16'(`MCU_ADR_PORTA + p), rand8());
                bus_read(16'(`MCU_ADR_PORTA + p));
                bus_read(16'(`MCU_ADR_DDRA + p));
            end
            bus_read(`MCU_ADR_PORTD);
        end
        close_test("ports");
    endtask

    task automatic test_sci_control();
        open_test();
        // Status straight out of reset
        bus_read(`MCU_ADR_SCSR);
        repeat (4) begin
            bus_write(`MCU_ADR_SCBR, rand8());
            bus_write(`MCU_ADR_SCCR1, rand8());
            bus_write(`MCU_ADR_SCCR2, rand8());
            bus_read(`MCU_ADR_SCBR);
            bus_read(`MCU_ADR_SCCR1);
            bus_read(`MCU_ADR_SCCR2);
            bus_write(`MCU_ADR_SCDR, rand8());
        end
        close_test("serial transmit and control");
    endtask

    task automatic test_sci_receive();
        open_test();
        bus_write(`MCU_ADR_SCCR2, 8'h2C);
        repeat (5) begin
            rx_byte(rand8());
            bus_read(`MCU_ADR_SCSR);
            bus_read(`MCU_ADR_SCDR);
            bus_read(`MCU_ADR_SCSR);
        end
        // Second byte overwrites the first
        rx_byte(rand8());
        rx_byte(rand8());
        bus_read(`MCU_ADR_SCDR);
        // Flag without the interrupt enable
        bus_write(`MCU_ADR_SCCR2, 8'h0C);
        rx_byte(rand8());
        bus_read(`MCU_ADR_SCSR);
        bus_read(`MCU_ADR_SCDR);
        close_test("serial receive");
    endtask

    task automatic test_counter();
        int n;
        open_test();
        repeat (20) begin
            n = $random(seed) & 7;
            // Unmapped reads advance the counter and return zero
            repeat (n) bus_read({rand8() | 8'h01, rand8()});
            bus_read(`MCU_ADR_ALT_HI);
            bus_read(`MCU_ADR_ALT_LO);
        end
        close_test("counter");
    endtask

    task automatic test_capture_compare();
        logic [15:0] target;
        open_test();
        bus_write(`MCU_ADR_TCR, 8'h82);
        repeat (3) bus_read(`MCU_ADR_TSR);
        tcap = 1'b1;
        wait_timer_irq("capture");
        bus_read(`MCU_ADR_ICH);
        bus_read(`MCU_ADR_ICL);
        bus_read(`MCU_ADR_TSR);

        // Compare value a few counts ahead
        bus_write(`MCU_ADR_TCR, 8'h40);
        target = 16'(bus_cycles / timer_prescale + 3);
        bus_write(`MCU_ADR_OCH, target[15:8]);
        bus_write(`MCU_ADR_OCL, target[7:0]);
        wait_timer_irq("compare");
        bus_read(`MCU_ADR_TSR);
        bus_write(`MCU_ADR_OCL, target[7:0]);
        bus_read(`MCU_ADR_TSR);

        // Flags still set with both enables off, interrupt stays low
        bus_write(`MCU_ADR_TCR, 8'h00);
        tcap = 1'b0;
        target = 16'(bus_cycles / timer_prescale + 3);
        bus_write(`MCU_ADR_OCH, target[15:8]);
        bus_write(`MCU_ADR_OCL, target[7:0]);
        repeat (30) bus_read(`MCU_ADR_TSR);
        bus_read(`MCU_ADR_ICH);
        bus_read(`MCU_ADR_ICL);
        bus_read(`MCU_ADR_TSR);
        close_test("capture and compare");
    endtask

    initial begin
        int total;
        reset    = 1'b1;
        cycle    = 1'b0;
        addr     = '0;
        wr       = 1'b0;
        wdata    = '0;
        porta_in = '0;
        portb_in = '0;
        portc_in = '0;
        portd_in = '0;
        tcap     = 1'b0;
        rx_valid = 1'b0;
        rx_data  = '0;
        repeat (2) @(posedge clk30);
        @(negedge clk30);
        reset = 1'b0;

        test_ports();
        test_sci_control();
        test_sci_receive();
        test_counter();
        test_capture_compare();

        total = dut_i.chk_i.fail_count + tb_errors;
        $display("%0d tests run, %0d failures", tests_run, total);
        if (total == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
